// File: src/fpm_consts.svh
`ifndef FPM_CONSTS_SVH
`define FPM_CONSTS_SVH

// exponent width, two's complement
`define FPM_EXP_W 8

// mantissa width, two's complement
`define FPM_MANT_W 40

// alignment shift counter width
`define FPM_CNT_W 6

// difference magnitude from which no alignment is done
`define FPM_G_LIMIT 40

// length of the exponent overflow interrupt pulse, in clocks
`define FPM_FI_TICKS 5

`endif

// File: src/fpm_pkg.sv
`include "fpm_consts.svh"

package fpm_pkg;

	// 8-bit two's complement exponent
	typedef logic [`FPM_EXP_W-1:0] exp_t;

	// exponent with two extension bits on top
	// bit 9 is the sum_c_2 position, bit 8 the sum_c_1 position
	typedef logic [`FPM_EXP_W+1:0] exp_ext_t;

	// 40-bit two's complement mantissa
	typedef logic [`FPM_MANT_W-1:0] mant_t;

	// alignment step count
	typedef logic [`FPM_CNT_W-1:0] shcnt_t;

	// instruction code field
	typedef logic [2:0] opcode_t;

	// microoperation sequencer
	typedef enum logic [2:0] {
		st_idle,
		st_decode,
		st_add,
		st_shift,
		st_finish
	} seq_state_e;

endpackage

// File: src/fpm_opdec.sv
`timescale 1ns/1ps

module fpm_opdec
	import fpm_pkg::*;
(
	input  logic    f2strob,
	input  logic    arst_n,
	input  logic    dec_load,
	input  opcode_t opcode,
	input  logic    float_op,
	output logic    af,
	output logic    sf,
	output logic    mf,
	output logic    df,
	output logic    fixed
);

	logic [7:0] lines;
	logic       float_ok;

	// one line per code: ad sd mw dw af sf mf df
	assign lines = 8'b0000_0001 << opcode;

	// floating codes only count with the qualifier set
	assign float_ok = float_op & opcode[2];

	// decode held for the whole operation
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			af    <= 1'b0;
			sf    <= 1'b0;
			mf    <= 1'b0;
			df    <= 1'b0;
			fixed <= 1'b0;
		end else if (dec_load) begin
			af    <= lines[4] & float_op;
			sf    <= lines[5] & float_op;
			mf    <= lines[6] & float_op;
			df    <= lines[7] & float_op;
			// ad, sd, mw, dw and unqualified codes
			fixed <= ~float_ok;
		end
	end

endmodule

// File: src/fpm_exponent.sv
`timescale 1ns/1ps

`include "fpm_consts.svh"

module fpm_exponent
	import fpm_pkg::*;
(
	input  logic   f2strob,
	input  logic   arst_n,
	input  logic   load_ops,
	input  logic   add_step,
	input  logic   af,
	input  logic   sf,
	input  logic   mf,
	input  logic   df,
	input  exp_t   exp_a,
	input  exp_t   exp_b,
	output logic   diff_neg,
	output logic   ge_limit,
	output logic   exp_ovf,
	output shcnt_t shift_amount,
	output exp_t   res_exp
);

	exp_t     d_reg;
	exp_t     b_reg;
	exp_ext_t d_ext;
	exp_ext_t b_bus;
	exp_ext_t sum_ext;
	exp_ext_t diff_mag;
	logic     subtract;
	logic     add_sub_op;
	logic     in_range;

	// D and B operand registers
	always_ff @(posedge f2strob) begin
		if (load_ops) begin
			d_reg <= exp_a;
			b_reg <= exp_b;
		end
	end

	assign add_sub_op = af | sf;

	// B bus is complemented with carry-in for everything but mf
	assign subtract = af | sf | df;

	assign d_ext = {{2{d_reg[`FPM_EXP_W-1]}}, d_reg};

	always_comb begin
		b_bus = {{2{b_reg[`FPM_EXP_W-1]}}, b_reg};
		if (subtract) begin
			b_bus = ~b_bus;
		end
	end

	// 10-bit adder, extension bits carry sign and overflow
	assign sum_ext = d_ext + b_bus + exp_ext_t'(subtract);

	// sign of D - B, set when exp_b is the larger one
	assign diff_neg = sum_ext[`FPM_EXP_W+1];

	assign diff_mag = diff_neg ? (~sum_ext + 1'b1) : sum_ext;

	assign ge_limit = diff_mag >= exp_ext_t'(`FPM_G_LIMIT);

	// counter gets zero unless an alignment is due
	assign shift_amount = (add_sub_op && !ge_limit) ? diff_mag[`FPM_CNT_W-1:0] : '0;

	// top three bits must agree for a result in -128..127
	assign in_range = (sum_ext[`FPM_EXP_W+1:`FPM_EXP_W-1] == 3'b000) ||
		(sum_ext[`FPM_EXP_W+1:`FPM_EXP_W-1] == 3'b111);

	assign exp_ovf = (mf | df) & ~in_range;

	// result exponent, taken in the add cycle
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			res_exp <= '0;
		end else if (add_step) begin
			if (add_sub_op) begin
				// larger exponent survives alignment
				res_exp <= diff_neg ? b_reg : d_reg;
			end else begin
				res_exp <= sum_ext[`FPM_EXP_W-1:0];
			end
		end
	end

endmodule

// File: src/fpm_shift_counter.sv
`timescale 1ns/1ps

module fpm_shift_counter
	import fpm_pkg::*;
(
	input  logic   f2strob,
	input  logic   arst_n,
	input  logic   cnt_load,
	input  logic   shift_step,
	input  shcnt_t shift_amount,
	output logic   cnt_zero
);

	shcnt_t count;

	// down-counter of remaining alignment steps
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			count    <= '0;
			cnt_zero <= 1'b1;
		end else if (cnt_load) begin
			count    <= shift_amount;
			cnt_zero <= (shift_amount == '0);
		end else if (shift_step) begin
			count    <= count - 1'b1;
			// last step brings the count to zero
			cnt_zero <= (count == shcnt_t'(1));
		end
	end

endmodule

// File: src/fpm_align.sv
`timescale 1ns/1ps

`include "fpm_consts.svh"

module fpm_align
	import fpm_pkg::*;
(
	input  logic  f2strob,
	input  logic  arst_n,
	input  logic  load_ops,
	input  logic  shift_step,
	input  logic  diff_neg,
	input  mant_t mant_a,
	input  mant_t mant_b,
	output mant_t res_mant_a,
	output mant_t res_mant_b
);

	mant_t shr_a;
	mant_t shr_b;

	// one-bit arithmetic right shift, sign copied in
	assign shr_a = {res_mant_a[`FPM_MANT_W-1], res_mant_a[`FPM_MANT_W-1:1]};
	assign shr_b = {res_mant_b[`FPM_MANT_W-1], res_mant_b[`FPM_MANT_W-1:1]};

	// mantissa A register
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			res_mant_a <= '0;
		end else if (load_ops) begin
			res_mant_a <= mant_a;
		end else if (shift_step && diff_neg) begin
			// exp_a is the smaller one
			res_mant_a <= shr_a;
		end
	end

	// mantissa B register
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			res_mant_b <= '0;
		end else if (load_ops) begin
			res_mant_b <= mant_b;
		end else if (shift_step && !diff_neg) begin
			res_mant_b <= shr_b;
		end
	end

endmodule

// File: src/fpm_seq.sv
`timescale 1ns/1ps

`include "fpm_consts.svh"

module fpm_seq
	import fpm_pkg::*;
(
	input  logic f2strob,
	input  logic arst_n,
	input  logic start,
	input  logic af,
	input  logic sf,
	input  logic mf,
	input  logic df,
	input  logic fixed_op,
	input  logic ge_limit,
	input  logic diff_neg,
	input  logic exp_ovf_in,
	input  logic cnt_zero,
	output logic dec_load,
	output logic load_ops,
	output logic add_step,
	output logic cnt_load,
	output logic shift_step,
	output logic done,
	output logic g,
	output logic wdt,
	output logic fixed,
	output logic exp_ovf,
	output logic fi
);

	localparam int fi_cnt_w = $clog2(`FPM_FI_TICKS);

	seq_state_e          state;
	seq_state_e          next_state;
	logic                accept;
	logic                align_due;
	logic [fi_cnt_w-1:0] fi_cnt;

	// start only counts in idle
	assign accept = (state == st_idle) & start;

	// af/sf within range need the shift phase
	assign align_due = (af | sf) & ~ge_limit;

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (start) begin
					next_state = st_decode;
				end
			end
			st_decode: begin
				next_state = fixed_op ? st_finish : st_add;
			end
			st_add: begin
				next_state = align_due ? st_shift : st_finish;
			end
			st_shift: begin
				if (cnt_zero) begin
					next_state = st_idle;
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	// microoperation enables
	assign dec_load   = accept;
	assign load_ops   = (state == st_decode);
	assign add_step   = (state == st_add);
	assign cnt_load   = (state == st_add);
	assign shift_step = (state == st_shift) & ~cnt_zero;

	// end of alignment also ends the operation
	assign done = (state == st_finish) | ((state == st_shift) & cnt_zero);

	// G, WDT, fixed and overflow flags
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			g       <= 1'b0;
			wdt     <= 1'b0;
			fixed   <= 1'b0;
			exp_ovf <= 1'b0;
		end else if (accept) begin
			g       <= 1'b0;
			wdt     <= 1'b0;
			fixed   <= 1'b0;
			exp_ovf <= 1'b0;
		end else if (state == st_decode) begin
			fixed <= fixed_op;
		end else if (state == st_add) begin
			g       <= (af | sf) & ge_limit;
			wdt     <= (af | sf) & diff_neg & ~ge_limit;
			exp_ovf <= (mf | df) & exp_ovf_in;
		end
	end

	// interrupt pulse stretcher, first tick is the finish cycle itself
	always_ff @(posedge f2strob or negedge arst_n) begin
		if (!arst_n) begin
			fi_cnt <= '0;
		end else if ((state == st_finish) && exp_ovf) begin
			fi_cnt <= fi_cnt_w'(`FPM_FI_TICKS - 1);
		end else if (fi_cnt != '0) begin
			fi_cnt <= fi_cnt - 1'b1;
		end
	end

	assign fi = ((state == st_finish) & exp_ovf) | (fi_cnt != '0);

endmodule

// File: src/fpm_top.sv
`timescale 1ns/1ps

module fpm_top
	import fpm_pkg::*;
(
	input  logic    f2strob,
	input  logic    arst_n,
	input  logic    start,
	input  opcode_t opcode,
	input  logic    float_op,
	input  exp_t    exp_a,
	input  exp_t    exp_b,
	input  mant_t   mant_a,
	input  mant_t   mant_b,
	output logic    done,
	output exp_t    res_exp,
	output mant_t   res_mant_a,
	output mant_t   res_mant_b,
	output logic    g,
	output logic    wdt,
	output logic    fixed,
	output logic    exp_ovf,
	output logic    fi
);

	logic   af;
	logic   sf;
	logic   mf;
	logic   df;
	logic   fixed_dec;
	logic   dec_load;
	logic   load_ops;
	logic   add_step;
	logic   cnt_load;
	logic   shift_step;
	logic   diff_neg;
	logic   ge_limit;
	logic   exp_ovf_raw;
	logic   cnt_zero;
	shcnt_t shift_amount;

	fpm_opdec fpm_opdec_inst (
		.f2strob  (f2strob),
		.arst_n   (arst_n),
		.dec_load (dec_load),
		.opcode   (opcode),
		.float_op (float_op),
		.af       (af),
		.sf       (sf),
		.mf       (mf),
		.df       (df),
		.fixed    (fixed_dec)
	);

	fpm_exponent fpm_exponent_inst (
		.f2strob      (f2strob),
		.arst_n       (arst_n),
		.load_ops     (load_ops),
		.add_step     (add_step),
		.af           (af),
		.sf           (sf),
		.mf           (mf),
		.df           (df),
		.exp_a        (exp_a),
		.exp_b        (exp_b),
		.diff_neg     (diff_neg),
		.ge_limit     (ge_limit),
		.exp_ovf      (exp_ovf_raw),
		.shift_amount (shift_amount),
		.res_exp      (res_exp)
	);

	fpm_shift_counter fpm_shift_counter_inst (
		.f2strob      (f2strob),
		.arst_n       (arst_n),
		.cnt_load     (cnt_load),
		.shift_step   (shift_step),
		.shift_amount (shift_amount),
		.cnt_zero     (cnt_zero)
	);

	fpm_align fpm_align_inst (
		.f2strob    (f2strob),
		.arst_n     (arst_n),
		.load_ops   (load_ops),
		.shift_step (shift_step),
		.diff_neg   (diff_neg),
		.mant_a     (mant_a),
		.mant_b     (mant_b),
		.res_mant_a (res_mant_a),
		.res_mant_b (res_mant_b)
	);

	fpm_seq fpm_seq_inst (
		.f2strob    (f2strob),
		.arst_n     (arst_n),
		.start      (start),
		.af         (af),
		.sf         (sf),
		.mf         (mf),
		.df         (df),
		.fixed_op   (fixed_dec),
		.ge_limit   (ge_limit),
		.diff_neg   (diff_neg),
		.exp_ovf_in (exp_ovf_raw),
		.cnt_zero   (cnt_zero),
		.dec_load   (dec_load),
		.load_ops   (load_ops),
		.add_step   (add_step),
		.cnt_load   (cnt_load),
		.shift_step (shift_step),
		.done       (done),
		.g          (g),
		.wdt        (wdt),
		.fixed      (fixed),
		.exp_ovf    (exp_ovf),
		.fi         (fi)
	);

endmodule

// File: sim/fpm_tb_vectors.svh
`ifndef FPM_TB_VECTORS_SVH
`define FPM_TB_VECTORS_SVH

// columns: opcode, float_op, exp_a, exp_b, mant_a, mant_b,
// res_exp, res_mant_a, res_mant_b, g, wdt, fixed, exp_ovf, res_exp checked, poke, latency
task automatic fill_table();
	// af, exp_a larger by 3
	add_row(3'd4, 1'b1, 8'h0a, 8'h07, 40'h12_3456_789a, 40'h40_0000_0008,
		8'h0a, 40'h12_3456_789a, 40'h08_0000_0001, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 7);
	// sf, exp_b larger, negative mant_a gets its sign copied in
	add_row(3'd5, 1'b1, 8'hfb, 8'h02, 40'h80_0000_0080, 40'h7f_ffff_ffff,
		8'h02, 40'hff_0000_0001, 40'h7f_ffff_ffff, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 11);
	// difference exactly at the limit, both ways
	add_row(3'd4, 1'b1, 8'h32, 8'h0a, 40'ha5_a5a5_a5a5, 40'h5a_5a5a_5a5a,
		8'h32, 40'ha5_a5a5_a5a5, 40'h5a_5a5a_5a5a, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4);
	add_row(3'd5, 1'b1, 8'h00, 8'h28, 40'h80_0000_0000, 40'h00_0000_0001,
		8'h28, 40'h80_0000_0000, 40'h00_0000_0001, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4);
	// far apart
	add_row(3'd5, 1'b1, 8'h9c, 8'h64, 40'h01_2345_6789, 40'hfe_dcba_9876,
		8'h64, 40'h01_2345_6789, 40'hfe_dcba_9876, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4);
	// equal exponents, no shift
	add_row(3'd4, 1'b1, 8'h14, 8'h14, 40'hc0_0000_0000, 40'h80_0000_0001,
		8'h14, 40'hc0_0000_0000, 40'h80_0000_0001, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4);
	// longest alignment
	add_row(3'd4, 1'b1, 8'h00, 8'h27, 40'h80_0000_0000, 40'h11_1111_1111,
		8'h27, 40'hff_ffff_ffff, 40'h11_1111_1111, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 43);
	// start pulse while aligning is ignored
	add_row(3'd4, 1'b1, 8'h1e, 8'h00, 40'h33_3333_3333, 40'h40_0000_0000,
		8'h1e, 40'h33_3333_3333, 40'h00_0000_0100, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 34);
	// mf and df in range
	add_row(3'd6, 1'b1, 8'h14, 8'h1e, 40'h00_0000_00ff, 40'h00_0000_ff00,
		8'h32, 40'h00_0000_00ff, 40'h00_0000_ff00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4);
	add_row(3'd7, 1'b1, 8'hec, 8'h1e, 40'h55_0000_0055, 40'haa_0000_00aa,
		8'hce, 40'h55_0000_0055, 40'haa_0000_00aa, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4);
	add_row(3'd6, 1'b1, 8'h7f, 8'h00, 40'h0f_0f0f_0f0f, 40'hf0_f0f0_f0f0,
		8'h7f, 40'h0f_0f0f_0f0f, 40'hf0_f0f0_f0f0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4);
	// mf and df overflowing, fi pulse
	add_row(3'd6, 1'b1, 8'h64, 8'h64, 40'h01_0000_0000, 40'h02_0000_0000,
		8'hc8, 40'h01_0000_0000, 40'h02_0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4);
	add_row(3'd7, 1'b1, 8'h9c, 8'h64, 40'h03_0000_0000, 40'h04_0000_0000,
		8'h38, 40'h03_0000_0000, 40'h04_0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4);
	add_row(3'd6, 1'b1, 8'h80, 8'h80, 40'h05_0000_0000, 40'h06_0000_0000,
		8'h00, 40'h05_0000_0000, 40'h06_0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4);
	add_row(3'd7, 1'b1, 8'h80, 8'h01, 40'h07_0000_0000, 40'h08_0000_0000,
		8'h7f, 40'h07_0000_0000, 40'h08_0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4);
	// fixed codes and unqualified floating codes
	add_row(3'd0, 1'b1, 8'h0a, 8'h07, 40'h12_0000_0034, 40'h56_0000_0078,
		8'h00, 40'h12_0000_0034, 40'h56_0000_0078, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3);
	add_row(3'd4, 1'b0, 8'h00, 8'h05, 40'h80_0000_0000, 40'h40_0000_0000,
		8'h00, 40'h80_0000_0000, 40'h40_0000_0000, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3);
	add_row(3'd3, 1'b0, 8'h11, 8'h22, 40'h9a_bcde_f012, 40'h34_5678_9abc,
		8'h00, 40'h9a_bcde_f012, 40'h34_5678_9abc, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3);
	add_row(3'd6, 1'b0, 8'h64, 8'h64, 40'h00_0000_0001, 40'h00_0000_0002,
		8'h00, 40'h00_0000_0001, 40'h00_0000_0002, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3);
endtask

`endif

// File: sim/fpm_tb.sv
`timescale 1ns/1ps

`include "fpm_consts.svh"

module fpm_tb
	import fpm_pkg::*;
();

	typedef struct packed {
		opcode_t    opcode;
		logic       float_op;
		exp_t       exp_a;
		exp_t       exp_b;
		mant_t      mant_a;
		mant_t      mant_b;
		exp_t       res_exp;
		mant_t      res_a;
		mant_t      res_b;
		logic       g;
		logic       wdt;
		logic       fixed;
		logic       exp_ovf;
		logic       chk_exp;
		logic       poke;
		logic [7:0] lat;
	} vec_t;

	logic    f2strob;
	logic    arst_n;
	logic    start;
	opcode_t opcode;
	logic    float_op;
	exp_t    exp_a;
	exp_t    exp_b;
	mant_t   mant_a;
	mant_t   mant_b;
	logic    done;
	exp_t    res_exp;
	mant_t   res_mant_a;
	mant_t   res_mant_b;
	logic    g;
	logic    wdt;
	logic    fixed;
	logic    exp_ovf;
	logic    fi;
	integer  seed;
	vec_t    table_rows [$];

	`include "fpm_tb_vectors.svh"

	fpm_top fpm_top_inst (
		.f2strob    (f2strob),
		.arst_n     (arst_n),
		.start      (start),
		.opcode     (opcode),
		.float_op   (float_op),
		.exp_a      (exp_a),
		.exp_b      (exp_b),
		.mant_a     (mant_a),
		.mant_b     (mant_b),
		.done       (done),
		.res_exp    (res_exp),
		.res_mant_a (res_mant_a),
		.res_mant_b (res_mant_b),
		.g          (g),
		.wdt        (wdt),
		.fixed      (fixed),
		.exp_ovf    (exp_ovf),
		.fi         (fi)
	);

	// 4 ns period
	always #2 f2strob = ~f2strob;

	task automatic stop_on_error();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_exp(input string name, input exp_t got, input exp_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_mant(input string name, input mant_t got, input mant_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string name, input int got, input int want);
		if (got != want) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic add_row(input opcode_t op, input logic fl, input exp_t ea, input exp_t eb,
		input mant_t ma, input mant_t mb, input exp_t rexp, input mant_t ra, input mant_t rb,
		input logic eg, input logic ewdt, input logic efix, input logic eovf, input logic chk,
		input logic pk, input int lat);
		vec_t row;
		row = {op, fl, ea, eb, ma, mb, rexp, ra, rb, eg, ewdt, efix, eovf, chk, pk, 8'(lat)};
		table_rows.push_back(row);
	endtask

	// one operation, cycles counts from the start cycle up to the done cycle
	task automatic run_op(input opcode_t op, input logic fl, input exp_t ea, input exp_t eb,
		input mant_t ma, input mant_t mb, input logic pk, output int cycles);
		logic seen;
		@(posedge f2strob);
		start    <= 1'b1;
		opcode   <= op;
		float_op <= fl;
		exp_a    <= ea;
		exp_b    <= eb;
		mant_a   <= ma;
		mant_b   <= mb;
		cycles = 1;
		seen = 1'b0;
		while (!seen) begin
			@(posedge f2strob);
			cycles = cycles + 1;
			if (pk && cycles == 8) begin
				// second request in the middle of the alignment
				start  <= 1'b1;
				opcode <= 3'd6;
				exp_a  <= ~ea;
				exp_b  <= ~eb;
				mant_a <= ~ma;
				mant_b <= ~mb;
			end else begin
				start <= 1'b0;
			end
			@(negedge f2strob);
			seen = done;
			if (!seen && cycles >= 100) begin
				$display("timeout: done did not arrive within 100 clocks");
				stop_on_error();
			end
		end
	endtask

	task automatic check_results(input exp_t rexp, input mant_t ra, input mant_t rb,
		input logic eg, input logic ewdt, input logic efix, input logic eovf,
		input logic chk, input int elat, input int lat);
		if (chk) begin
			check_exp("res_exp", res_exp, rexp);
		end
		check_mant("res_mant_a", res_mant_a, ra);
		check_mant("res_mant_b", res_mant_b, rb);
		check_flag("g", g, eg);
		check_flag("wdt", wdt, ewdt);
		check_flag("fixed", fixed, efix);
		check_flag("exp_ovf", exp_ovf, eovf);
		check_count("latency", lat, elat);
	endtask

	// fi length counted from the done cycle
	task automatic check_fi(input logic eovf);
		int ticks;
		ticks = 0;
		while (fi) begin
			ticks = ticks + 1;
			if (ticks > 20) begin
				$display("timeout: fi stayed high for more than 20 clocks");
				stop_on_error();
			end
			@(negedge f2strob);
		end
		check_count("fi length", ticks, eovf ? `FPM_FI_TICKS : 0);
	endtask

	// reference for af/sf, straight from the alignment rules
	task automatic model_align(input exp_t ea, input exp_t eb, input mant_t ma,
		input mant_t mb, output exp_t rexp, output mant_t ra, output mant_t rb,
		output logic eg, output logic ewdt, output int elat);
		int diff;
		int mag;
		diff = int'($signed(ea)) - int'($signed(eb));
		mag = (diff < 0) ? -diff : diff;
		eg = (mag >= `FPM_G_LIMIT);
		ewdt = (diff < 0) && !eg;
		rexp = (diff < 0) ? eb : ea;
		ra = ma;
		rb = mb;
		elat = 4;
		if (!eg) begin
			elat = 4 + mag;
			if (diff < 0) begin
				ra = $signed(ma) >>> mag;
			end else begin
				rb = $signed(mb) >>> mag;
			end
		end
	endtask

	task automatic run_random();
		opcode_t op;
		exp_t    ea;
		exp_t    eb;
		mant_t   ma;
		mant_t   mb;
		exp_t    rexp;
		mant_t   ra;
		mant_t   rb;
		logic    eg;
		logic    ewdt;
		int      elat;
		int      lat;
		for (int i = 0; i < 30; i++) begin
			op = opcode_t'(4 + ($random(seed) & 1));
			// nearby exponents so that most vectors need a shift
			ea = exp_t'(($random(seed) & 127) - 64);
			eb = exp_t'(int'($signed(ea)) + $random(seed) % 48);
			ma = mant_t'({$random(seed), $random(seed)});
			mb = mant_t'({$random(seed), $random(seed)});
			model_align(ea, eb, ma, mb, rexp, ra, rb, eg, ewdt, elat);
			run_op(op, 1'b1, ea, eb, ma, mb, 1'b0, lat);
			check_results(rexp, ra, rb, eg, ewdt, 1'b0, 1'b0, 1'b1, elat, lat);
			check_fi(1'b0);
		end
	endtask

	initial begin
		vec_t row;
		int   lat;
		seed     = 32'hba9e;
		f2strob  = 1'b0;
		arst_n   = 1'b0;
		start    = 1'b0;
		opcode   = '0;
		float_op = 1'b0;
		exp_a    = '0;
		exp_b    = '0;
		mant_a   = '0;
		mant_b   = '0;
		repeat (4) @(posedge f2strob);
		arst_n <= 1'b1;
		@(negedge f2strob);
		check_flag("done after reset", done, 1'b0);
		check_flag("fi after reset", fi, 1'b0);
		check_flag("g after reset", g, 1'b0);
		check_flag("wdt after reset", wdt, 1'b0);
		check_flag("fixed after reset", fixed, 1'b0);
		check_flag("exp_ovf after reset", exp_ovf, 1'b0);
		fill_table();
		for (int i = 0; i < table_rows.size(); i++) begin
			row = table_rows[i];
			run_op(row.opcode, row.float_op, row.exp_a, row.exp_b, row.mant_a, row.mant_b,
				row.poke, lat);
			check_results(row.res_exp, row.res_a, row.res_b, row.g, row.wdt, row.fixed,
				row.exp_ovf, row.chk_exp, int'(row.lat), lat);
			check_fi(row.exp_ovf);
		end
		run_random();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+src
+incdir+sim
src/fpm_pkg.sv
src/fpm_opdec.sv
src/fpm_exponent.sv
src/fpm_shift_counter.sv
src/fpm_align.sv
src/fpm_seq.sv
src/fpm_top.sv
sim/fpm_tb.sv
